// File: rv_core.f
rtl/rv_core_pkg.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/exec_stage.sv
rtl/rv_core.sv
tb/rv_core_checker.sv
tb/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - rtl/rv_core_pkg.sv
  - rtl/fetch_unit.sv
  - rtl/decode_stage.sv
  - rtl/exec_stage.sv
  - rtl/rv_core.sv
  - target: test
    files:
      - tb/rv_core_checker.sv
      - tb/rv_core_tb.sv

// File: tb/rv_core_tb.sv
module rv_core_tb import rv_core_pkg::*; ();

    localparam word_t RESET_PC    = 32'h0000_0100;
    localparam int    CLK_PERIOD  = 100;
    localparam int    DRIVE_DELAY = 10;
    localparam int    PROG_WORDS  = 64;
    localparam int    RETIRE_GOAL = 400;
    localparam int    WAIT_LIMIT  = 200;
    localparam int    RUN_LIMIT   = 20000;

    logic     clk = 1'b0;
    logic     reset;
    logic     imem_req;
    word_t    imem_addr;
    logic     imem_ack;
    word_t    imem_data;
    logic     retire_valid;
    logic     retire_ready;
    word_t    retire_pc;
    logic     retire_we;
    reg_idx_t retire_rd;
    word_t    retire_data;
    int       errors;
    int       retired;
    int       timeouts = 0;
    int       seed = 85;
    // own stream for back-pressure
    int       ready_seed = 86;
    word_t    prog [PROG_WORDS];

    always #(CLK_PERIOD / 2) clk = ~clk;

    rv_core #(
        .RESET_PC(RESET_PC)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_ack    (imem_ack),
        .imem_data   (imem_data),
        .retire_valid(retire_valid),
        .retire_ready(retire_ready),
        .retire_pc   (retire_pc),
        .retire_we   (retire_we),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    rv_core_checker #(
        .RESET_PC(RESET_PC)
    ) chk0 (
        .clk         (clk),
        .reset       (reset),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .retire_valid(retire_valid),
        .retire_ready(retire_ready),
        .retire_pc   (retire_pc),
        .retire_we   (retire_we),
        .retire_rd   (retire_rd),
        .retire_data (retire_data),
        .errors      (errors),
        .retired     (retired)
    );

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic pause();
        repeat ({$random(seed)} % 4) next_cycle();
    endtask

    task automatic wait_req(input logic level);
        int n;
        n = 0;
        while (imem_req !== level && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (imem_req !== level) begin
            $display("timeout: imem_req did not change to %0b within %0d cycles",
                     level, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    // rv32e fields, forward branch and jump offsets to avoid tight loops
    function automatic word_t random_inst();
        word_t       r;
        word_t       s;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;

        r    = $random(seed);
        s    = $random(seed);
        rd   = r[7:4];
        rs1  = r[11:8];
        rs2  = r[15:12];
        f3   = r[18:16];
        imm  = s[31:20];
        boff = (s[3:0] == 4'd0) ? 13'd4 : {7'd0, s[3:0], 2'b00};
        joff = (s[3:0] == 4'd0) ? 21'd4 : {15'd0, s[3:0], 2'b00};
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                return {((f3 == F3_ADD || f3 == F3_SR) && s[0]) ? 7'h20 : 7'h00,
                        1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, OPC_OP, 2'b11};
            end
            4'd5, 4'd6, 4'd7, 4'd8: begin
                if (f3 == F3_SLL || f3 == F3_SR) begin
                    imm[11:5] = (f3 == F3_SR && s[0]) ? 7'h20 : 7'h00;
                end
                return {imm, 1'b0, rs1, f3, 1'b0, rd, OPC_OP_IMM, 2'b11};
            end
            4'd9:  return {s[31:12], 1'b0, rd, OPC_LUI, 2'b11};
            4'd10: return {s[31:12], 1'b0, rd, OPC_AUIPC, 2'b11};
            4'd11, 4'd12: begin
                // 010 and 011 are no branch kinds, fold them onto blt and bge
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    f3 = f3 ^ 3'b110;
                end
                return {boff[12], boff[10:5], 1'b0, rs2, 1'b0, rs1, f3,
                        boff[4:1], boff[11], OPC_BRANCH, 2'b11};
            end
            4'd13: return {joff[20], joff[10:1], joff[11], joff[19:12], 1'b0, rd, OPC_JAL, 2'b11};
            4'd14: return {4'd0, s[5:0], 2'b00, 5'd0, 3'b000, 1'b0, rd, OPC_JALR, 2'b11};
            default: begin
                // store or csr write, both retire as no-ops
                if (s[0]) begin
                    return {7'd0, 1'b0, rs2, 1'b0, rs1, 3'b010, 5'd4, 7'b0100011};
                end
                return {12'h300, 1'b0, rs1, 3'b001, 1'b0, rd, 7'b1110011};
            end
        endcase
    endfunction

    // prologue gives x1..x15 defined values before any random code
    task automatic build_program();
        word_t    r;
        reg_idx_t rd;
        for (int i = 0; i < PROG_WORDS; i++) begin
            if (i < 15) begin
                r  = $random(seed);
                rd = i[3:0] + 4'd1;
                prog[i] = {r[11:0], 5'd0, F3_ADD, 1'b0, rd, OPC_OP_IMM, 2'b11};
            end else begin
                prog[i] = random_inst();
            end
            chk0.prog[i] = prog[i];
        end
    endtask

    // instruction memory, pc wraps into the 64-word program
    initial begin : responder
        imem_ack  = 1'b0;
        imem_data = '0;
        while (timeouts == 0) begin
            wait_req(1'b1);
            pause();
            imem_data = prog[imem_addr[7:2]];
            imem_ack  = 1'b1;
            wait_req(1'b0);
            pause();
            imem_ack = 1'b0;
        end
    end

    initial begin : ready_driver
        retire_ready = 1'b0;
        forever begin
            next_cycle();
            retire_ready = ({$random(ready_seed)} % 10) < 7;
        end
    end

    initial begin : main_flow
        int n;
        reset = 1'b1;
        build_program();
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        n = 0;
        while (retired < RETIRE_GOAL && timeouts == 0 && n < RUN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (retired < RETIRE_GOAL && timeouts == 0) begin
            $display("timeout: only %0d of %0d instructions retired", retired, RETIRE_GOAL);
            timeouts++;
        end
        $display("%0d instructions retired, %0d errors, %0d timeouts",
                 retired, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: tb/rv_core_checker.sv
module rv_core_checker import rv_core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     imem_req,
    input  word_t    imem_addr,
    input  logic     retire_valid,
    input  logic     retire_ready,
    input  word_t    retire_pc,
    input  logic     retire_we,
    input  reg_idx_t retire_rd,
    input  word_t    retire_data,
    output int       errors,
    output int       retired
);

    // program image, loaded by the testbench before reset drops
    word_t    prog [64];
    word_t    regs [16];
    word_t    pc;
    logic     seen_req;
    logic     stalled;
    word_t    held_pc;
    logic     held_we;
    reg_idx_t held_rd;
    word_t    held_data;
    int       error_count = 0;
    int       retire_count = 0;

    assign errors  = error_count;
    assign retired = retire_count;

    task automatic compare(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAILED time %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    // architectural alu, alt selects sub and arithmetic shift
    function automatic word_t alu_result(input logic [2:0] f3, input logic alt,
                                         input word_t a, input word_t b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return {31'd0, $signed(a) < $signed(b)};
            F3_SLTU: return {31'd0, a < b};
            F3_XOR:  return a ^ b;
            F3_OR:   return a | b;
            F3_AND:  return a & b;
            default: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // executes the instruction at the model pc and checks the retirement
    task automatic retire_one();
        word_t      inst;
        op_class_t  opc;
        logic [2:0] f3;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_b;
        word_t      imm_j;
        word_t      data;
        word_t      next_pc;
        logic       we;
        logic       alt;

        inst    = prog[pc[7:2]];
        opc     = inst[6:2];
        f3      = inst[14:12];
        rd      = inst[10:7];
        a       = regs[inst[18:15]];
        b       = regs[inst[23:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_b   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        alt     = inst[30] && (opc == OPC_OP || f3 == F3_SR);
        we      = 1'b1;
        data    = '0;
        next_pc = pc + 32'd4;
        case (opc)
            OPC_LUI:    data = {inst[31:12], 12'd0};
            OPC_AUIPC:  data = pc + {inst[31:12], 12'd0};
            OPC_JAL: begin
                data    = pc + 32'd4;
                next_pc = pc + imm_j;
            end
            OPC_JALR: begin
                we   = (f3 == 3'b000);
                data = pc + 32'd4;
                if (we) begin
                    next_pc = (a + imm_i) & ~32'd1;
                end
            end
            OPC_BRANCH: begin
                we = 1'b0;
                if (branch_taken(f3, a, b)) begin
                    next_pc = pc + imm_b;
                end
            end
            OPC_OP_IMM: data = alu_result(f3, alt, a, imm_i);
            OPC_OP: begin
                // only the base register encodings write
                we   = (inst[31:25] == 7'h00 || inst[31:25] == 7'h20);
                data = alu_result(f3, alt, a, b);
            end
            default: we = 1'b0;
        endcase
        we = we && (rd != '0);

        compare("retire_pc", pc, retire_pc);
        compare("retire_we", we, retire_we);
        if (we) begin
            compare("retire_rd", rd, retire_rd);
            compare("retire_data", data, retire_data);
            regs[rd] = data;
        end
        pc = next_pc;
        retire_count++;
    endtask

    // sampled mid-cycle, away from the edge where everything moves
    always @(negedge clk) begin
        if (reset) begin
            compare("retire_valid", '0, retire_valid);
            compare("imem_req", '0, imem_req);
            pc       = RESET_PC;
            seen_req = 1'b0;
            stalled  = 1'b0;
            for (int i = 0; i < 16; i++) begin
                regs[i] = '0;
            end
        end else begin
            if (imem_req === 1'b1 && !seen_req) begin
                compare("imem_addr", RESET_PC, imem_addr);
                seen_req = 1'b1;
            end
            // a stalled retirement must not move
            if (stalled) begin
                compare("retire_valid", 32'd1, retire_valid);
                compare("retire_pc", held_pc, retire_pc);
                compare("retire_we", held_we, retire_we);
                compare("retire_rd", held_rd, retire_rd);
                compare("retire_data", held_data, retire_data);
            end
            if (retire_valid === 1'b1 && retire_ready === 1'b1) begin
                retire_one();
            end
            stalled   = (retire_valid === 1'b1) && (retire_ready !== 1'b1);
            held_pc   = retire_pc;
            held_we   = retire_we;
            held_rd   = retire_rd;
            held_data = retire_data;
        end
    end

endmodule

// File: rtl/rv_core.sv
module rv_core import rv_core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic     clk,
    input  logic     reset,
    output logic     imem_req,
    output word_t    imem_addr,
    input  logic     imem_ack,
    input  word_t    imem_data,
    output logic     retire_valid,
    input  logic     retire_ready,
    output word_t    retire_pc,
    output logic     retire_we,
    output reg_idx_t retire_rd,
    output word_t    retire_data
);

    // fetch to decode
    logic       if_valid;
    word_t      if_pc;
    word_t      if_inst;
    logic       id_ready;

    // decode to execute
    logic       id_valid;
    logic       ex_ready;
    word_t      id_pc;
    reg_idx_t   id_rd;
    reg_idx_t   id_rs1;
    reg_idx_t   id_rs2;
    word_t      id_imm;
    alu_op_t    id_alu_op;
    logic       id_use_imm;
    logic       id_reg_write;
    logic       id_lui;
    logic       id_auipc;
    logic       id_jal;
    logic       id_jalr;
    logic       id_branch;
    logic [2:0] id_func3;

    // taken branch or jump from execute
    logic       redirect;
    word_t      redirect_pc;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch0 (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_data  (imem_data),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .if_inst    (if_inst),
        .id_ready   (id_ready),
        .redirect   (redirect),
        .redirect_pc(redirect_pc)
    );

    decode_stage decode0 (
        .clk         (clk),
        .reset       (reset),
        .if_valid    (if_valid),
        .if_pc       (if_pc),
        .if_inst     (if_inst),
        .id_ready    (id_ready),
        .redirect    (redirect),
        .ex_ready    (ex_ready),
        .id_valid    (id_valid),
        .id_pc       (id_pc),
        .id_rd       (id_rd),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_imm      (id_imm),
        .id_alu_op   (id_alu_op),
        .id_use_imm  (id_use_imm),
        .id_reg_write(id_reg_write),
        .id_lui      (id_lui),
        .id_auipc    (id_auipc),
        .id_jal      (id_jal),
        .id_jalr     (id_jalr),
        .id_branch   (id_branch),
        .id_func3    (id_func3)
    );

    exec_stage exec0 (
        .clk         (clk),
        .reset       (reset),
        .id_valid    (id_valid),
        .ex_ready    (ex_ready),
        .id_pc       (id_pc),
        .id_rd       (id_rd),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_imm      (id_imm),
        .id_alu_op   (id_alu_op),
        .id_use_imm  (id_use_imm),
        .id_reg_write(id_reg_write),
        .id_lui      (id_lui),
        .id_auipc    (id_auipc),
        .id_jal      (id_jal),
        .id_jalr     (id_jalr),
        .id_branch   (id_branch),
        .id_func3    (id_func3),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .retire_valid(retire_valid),
        .retire_ready(retire_ready),
        .retire_pc   (retire_pc),
        .retire_we   (retire_we),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

endmodule

// File: rtl/exec_stage.sv
module exec_stage import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       id_valid,
    output logic       ex_ready,
    input  word_t      id_pc,
    input  reg_idx_t   id_rd,
    input  reg_idx_t   id_rs1,
    input  reg_idx_t   id_rs2,
    input  word_t      id_imm,
    input  alu_op_t    id_alu_op,
    input  logic       id_use_imm,
    input  logic       id_reg_write,
    input  logic       id_lui,
    input  logic       id_auipc,
    input  logic       id_jal,
    input  logic       id_jalr,
    input  logic       id_branch,
    input  logic [2:0] id_func3,
    output logic       redirect,
    output word_t      redirect_pc,
    output logic       retire_valid,
    input  logic       retire_ready,
    output word_t      retire_pc,
    output logic       retire_we,
    output reg_idx_t   retire_rd,
    output word_t      retire_data
);

    word_t      rf [16];
    word_t      ex_a;
    word_t      ex_b;
    word_t      ex_imm;
    alu_op_t    ex_alu_op;
    logic       ex_use_imm;
    logic       ex_reg_write;
    logic       ex_lui;
    logic       ex_auipc;
    logic       ex_jal;
    logic       ex_jalr;
    logic       ex_branch;
    logic [2:0] ex_func3;
    logic       fire;
    logic       accept;
    logic       cond;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      op_b;
    word_t      alu_out;

    // register file read with bypass from the retiring instruction
    function automatic word_t operand(input reg_idx_t idx, input word_t stored,
                                      input logic fwd, input reg_idx_t fwd_rd,
                                      input word_t fwd_data);
        if (idx == '0) begin
            return '0;
        end else if (fwd && fwd_rd == idx) begin
            return fwd_data;
        end
        return stored;
    endfunction

    assign fire     = retire_valid && retire_ready;
    assign ex_ready = !retire_valid || retire_ready;
    // wrong-path instruction in decode must not slip in behind a taken jump
    assign accept   = id_valid && ex_ready && !redirect;

    assign rs1_val = operand(id_rs1, rf[id_rs1], fire && retire_we, retire_rd, retire_data);
    assign rs2_val = operand(id_rs2, rf[id_rs2], fire && retire_we, retire_rd, retire_data);

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else if (accept) begin
            retire_valid <= 1'b1;
        end else if (retire_ready) begin
            retire_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            retire_pc    <= id_pc;
            retire_rd    <= id_rd;
            ex_a         <= rs1_val;
            ex_b         <= rs2_val;
            ex_imm       <= id_imm;
            ex_alu_op    <= id_alu_op;
            ex_use_imm   <= id_use_imm;
            ex_reg_write <= id_reg_write;
            ex_lui       <= id_lui;
            ex_auipc     <= id_auipc;
            ex_jal       <= id_jal;
            ex_jalr      <= id_jalr;
            ex_branch    <= id_branch;
            ex_func3     <= id_func3;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && retire_we) begin
            rf[retire_rd] <= retire_data;
        end
    end

    assign op_b = ex_use_imm ? ex_imm : ex_b;

    always_comb begin
        case (ex_alu_op)
            ALU_SUB:  alu_out = ex_a - op_b;
            ALU_AND:  alu_out = ex_a & op_b;
            ALU_OR:   alu_out = ex_a | op_b;
            ALU_XOR:  alu_out = ex_a ^ op_b;
            ALU_SLT:  alu_out = {31'b0, $signed(ex_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {31'b0, ex_a < op_b};
            ALU_SLL:  alu_out = ex_a << op_b[4:0];
            ALU_SRL:  alu_out = ex_a >> op_b[4:0];
            ALU_SRA:  alu_out = $signed(ex_a) >>> op_b[4:0];
            default:  alu_out = ex_a + op_b;
        endcase
    end

    // equal test for beq/bne, less-than bit otherwise, odd kinds inverted
    always_comb begin
        if (ex_func3 == F3_BEQ || ex_func3 == F3_BNE) begin
            cond = (alu_out == '0);
        end else begin
            cond = alu_out[0];
        end
        if (ex_func3 == F3_BNE || ex_func3 == F3_BGE || ex_func3 == F3_BGEU) begin
            cond = !cond;
        end
    end

    assign redirect    = fire && (ex_jal || ex_jalr || (ex_branch && cond));
    assign redirect_pc = ex_jalr ? ((ex_a + ex_imm) & ~32'd1) : retire_pc + ex_imm;

    assign retire_we = ex_reg_write && (retire_rd != '0);

    always_comb begin
        if (ex_lui) begin
            retire_data = ex_imm;
        end else if (ex_auipc) begin
            retire_data = retire_pc + ex_imm;
        end else if (ex_jal || ex_jalr) begin
            retire_data = retire_pc + 32'd4;
        end else begin
            retire_data = alu_out;
        end
    end

    a_retire_stable: assert property (@(posedge clk) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc)
            && $stable(retire_we) && $stable(retire_rd) && $stable(retire_data));

endmodule

// File: rtl/decode_stage.sv
module decode_stage import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     if_valid,
    input  word_t    if_pc,
    input  word_t    if_inst,
    output logic     id_ready,
    input  logic     redirect,
    input  logic     ex_ready,
    output logic     id_valid,
    output word_t    id_pc,
    output reg_idx_t id_rd,
    output reg_idx_t id_rs1,
    output reg_idx_t id_rs2,
    output word_t    id_imm,
    output alu_op_t  id_alu_op,
    output logic     id_use_imm,
    output logic     id_reg_write,
    output logic     id_lui,
    output logic     id_auipc,
    output logic     id_jal,
    output logic     id_jalr,
    output logic     id_branch,
    output logic [2:0] id_func3
);

    op_class_t  opc;
    logic [2:0] func3;
    logic [6:0] func7;
    logic       func7_5;
    logic       take;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;

    assign opc     = if_inst[6:2];
    assign func3   = if_inst[14:12];
    assign func7   = if_inst[31:25];
    assign func7_5 = if_inst[30];

    assign imm_i = {{20{if_inst[31]}}, if_inst[31:20]};
    assign imm_u = {if_inst[31:12], 12'b0};
    assign imm_b = {{20{if_inst[31]}}, if_inst[7], if_inst[30:25], if_inst[11:8], 1'b0};
    assign imm_j = {{12{if_inst[31]}}, if_inst[19:12], if_inst[20], if_inst[30:21], 1'b0};

    // slot frees up in the cycle execute takes it, closed during a flush
    assign id_ready = (ex_ready || !id_valid) && !redirect;
    assign take     = if_valid && id_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (redirect) begin
            id_valid <= 1'b0;
        end else if (take) begin
            id_valid <= 1'b1;
        end else if (ex_ready) begin
            id_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            id_pc    <= if_pc;
            id_rd    <= if_inst[10:7];
            id_rs1   <= if_inst[18:15];
            id_rs2   <= if_inst[23:20];
            id_func3 <= func3;

            // no-op unless a class below claims it
            id_imm       <= '0;
            id_alu_op    <= ALU_ADD;
            id_use_imm   <= 1'b0;
            id_reg_write <= 1'b0;
            id_lui       <= 1'b0;
            id_auipc     <= 1'b0;
            id_jal       <= 1'b0;
            id_jalr      <= 1'b0;
            id_branch    <= 1'b0;

            case (opc)
                OPC_LUI: begin
                    id_imm       <= imm_u;
                    id_reg_write <= 1'b1;
                    id_lui       <= 1'b1;
                end
                OPC_AUIPC: begin
                    id_imm       <= imm_u;
                    id_reg_write <= 1'b1;
                    id_auipc     <= 1'b1;
                end
                OPC_JAL: begin
                    id_imm       <= imm_j;
                    id_reg_write <= 1'b1;
                    id_jal       <= 1'b1;
                end
                OPC_JALR: begin
                    if (func3 == 3'b000) begin
                        id_imm       <= imm_i;
                        id_reg_write <= 1'b1;
                        id_jalr      <= 1'b1;
                    end
                end
                OPC_BRANCH: begin
                    id_imm <= imm_b;
                    case (func3)
                        F3_BEQ, F3_BNE: begin
                            id_alu_op <= ALU_SUB;
                            id_branch <= 1'b1;
                        end
                        F3_BLT, F3_BGE: begin
                            id_alu_op <= ALU_SLT;
                            id_branch <= 1'b1;
                        end
                        F3_BLTU, F3_BGEU: begin
                            id_alu_op <= ALU_SLTU;
                            id_branch <= 1'b1;
                        end
                        default: begin end
                    endcase
                end
                OPC_OP_IMM: begin
                    // shifts take the amount from imm[4:0]
                    id_imm       <= imm_i;
                    id_use_imm   <= 1'b1;
                    id_reg_write <= 1'b1;
                    case (func3)
                        F3_ADD:  id_alu_op <= ALU_ADD;
                        F3_SLL:  id_alu_op <= ALU_SLL;
                        F3_SLT:  id_alu_op <= ALU_SLT;
                        F3_SLTU: id_alu_op <= ALU_SLTU;
                        F3_XOR:  id_alu_op <= ALU_XOR;
                        F3_SR:   id_alu_op <= func7_5 ? ALU_SRA : ALU_SRL;
                        F3_OR:   id_alu_op <= ALU_OR;
                        default: id_alu_op <= ALU_AND;
                    endcase
                end
                OPC_OP: begin
                    // multiply and divide words fall through as no-ops
                    if (func7 == 7'h00 || func7 == 7'h20) begin
                        id_reg_write <= 1'b1;
                        case (func3)
                            F3_ADD:  id_alu_op <= func7_5 ? ALU_SUB : ALU_ADD;
                            F3_SLL:  id_alu_op <= ALU_SLL;
                            F3_SLT:  id_alu_op <= ALU_SLT;
                            F3_SLTU: id_alu_op <= ALU_SLTU;
                            F3_XOR:  id_alu_op <= ALU_XOR;
                            F3_SR:   id_alu_op <= func7_5 ? ALU_SRA : ALU_SRL;
                            F3_OR:   id_alu_op <= ALU_OR;
                            default: id_alu_op <= ALU_AND;
                        endcase
                    end
                end
                default: begin end
            endcase
        end
    end

    a_flush_clears: assert property (@(posedge clk) disable iff (reset)
        redirect |=> !id_valid);

endmodule

// File: rtl/fetch_unit.sv
module fetch_unit import rv_core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  reset,
    output logic  imem_req,
    output word_t imem_addr,
    input  logic  imem_ack,
    input  word_t imem_data,
    output logic  if_valid,
    output word_t if_pc,
    output word_t if_inst,
    input  logic  id_ready,
    input  logic  redirect,
    input  word_t redirect_pc
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_ACK,
        S_WAIT_REL,
        S_FULL
    } fetch_state_t;

    fetch_state_t state;
    word_t        pc;
    // request in flight belongs to a flushed path
    logic         discard;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            pc       <= RESET_PC;
            discard  <= 1'b0;
            imem_req <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            if (if_valid && id_ready) begin
                if_valid <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    imem_req  <= 1'b1;
                    imem_addr <= redirect ? redirect_pc : pc;
                    discard   <= 1'b0;
                    state     <= S_WAIT_ACK;
                end
                S_WAIT_ACK: begin
                    if (imem_ack) begin
                        imem_req <= 1'b0;
                        state    <= S_WAIT_REL;
                        if (!discard && !redirect) begin
                            if_valid <= 1'b1;
                            if_pc    <= imem_addr;
                            if_inst  <= imem_data;
                            pc       <= imem_addr + 32'd4;
                        end
                    end else if (redirect) begin
                        discard <= 1'b1;
                    end
                end
                S_WAIT_REL: begin
                    // responder has to drop ack before the next request
                    if (!imem_ack) begin
                        state <= S_FULL;
                    end
                end
                default: begin
                    if (!if_valid || id_ready || redirect) begin
                        state <= S_IDLE;
                    end
                end
            endcase
            if (redirect) begin
                pc       <= redirect_pc;
                if_valid <= 1'b0;
            end
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (reset)
        imem_req && !imem_ack |=> imem_req);

endmodule

// File: rtl/rv_core_pkg.sv
package rv_core_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [4:0]  op_class_t;

    // alu operation codes
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLT  = 4'd5;
    localparam alu_op_t ALU_SLTU = 4'd6;
    localparam alu_op_t ALU_SLL  = 4'd7;
    localparam alu_op_t ALU_SRL  = 4'd8;
    localparam alu_op_t ALU_SRA  = 4'd9;

    // opcode classes, instruction bits 6:2
    localparam op_class_t OPC_LUI    = 5'b01101;
    localparam op_class_t OPC_AUIPC  = 5'b00101;
    localparam op_class_t OPC_JAL    = 5'b11011;
    localparam op_class_t OPC_JALR   = 5'b11001;
    localparam op_class_t OPC_BRANCH = 5'b11000;
    localparam op_class_t OPC_OP_IMM = 5'b00100;
    localparam op_class_t OPC_OP     = 5'b01100;

    // branch kinds
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // register and immediate alu kinds
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage
